//--- include/mem_params.svh
// Size and address width macros for the byte-addressed data memory
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Total storage in bytes
`define MEM_BYTES 32

// Low address bits that select a byte, upper bits are ignored
`define MEM_ADDR_BITS 5

// Four byte lanes, so each lane holds a quarter of the bytes
`define MEM_ROWS (`MEM_BYTES / 4)

// Row index width inside one lane
`define MEM_ROW_BITS 3

// Number of byte lanes, one per byte of a word
`define MEM_LANES 4

`endif

//--- source/mem_pkg.sv
// Access width encoding and the word/byte union shared by the memory blocks
`default_nettype none

package mem_pkg;

   // Width field of a load or store, same encoding as the core's funct3 low bits
   typedef enum logic [1:0] {
      LEN_BYTE = 2'd0,
      LEN_HALF = 2'd1,
      LEN_WORD = 2'd2,
      // Reads as zero, writes nothing
      LEN_NONE = 2'd3
   } access_len_e;

   // One 32-bit word, seen whole or as four bytes
   // bytes[0] is the byte at the lowest address (little endian)
   typedef union packed {
      logic [31:0]       word;
      logic [3:0][7:0]   bytes;
   } mem_word_u;

endpackage

`default_nettype wire

//--- source/lane_bus_if.sv
// Per-lane bus between store steering, a byte bank and load merging
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

interface lane_bus_if;

   // Row inside the lane, used by reads and writes alike
   logic [`MEM_ROW_BITS-1:0] row;
   logic                     we;
   logic [7:0]               wdata;
   logic [7:0]               rdata;

   modport steer (
      output row,
      output we,
      output wdata
   );

   modport bank (
      input  row,
      input  we,
      input  wdata,
      output rdata
   );

   modport merge (
      input  rdata
   );

endinterface

`default_nettype wire

//--- source/store_lane_steer.sv
// Store steering: per-lane row, write enable and byte, plus high-water mark
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module store_lane_steer (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable,
   input  logic                       wr,
   input  mem_pkg::access_len_e       length,
   input  logic [31:0]                addr,
   input  logic [31:0]                data_in,
   lane_bus_if.steer                  lanes [`MEM_LANES],
   output logic [`MEM_ADDR_BITS-1:0]  highest_addr
);

   logic [1:0]                offset;
   logic [`MEM_ROW_BITS-1:0]  base_row;
   logic [`MEM_ROW_BITS-1:0]  next_row;
   logic [2:0]                num_bytes;
   logic                      store_active;
   mem_pkg::mem_word_u        store_u;

   logic [`MEM_ROW_BITS-1:0]  lane_row [`MEM_LANES];
   logic                      lane_we  [`MEM_LANES];
   logic [7:0]                lane_byte [`MEM_LANES];
   logic [`MEM_ADDR_BITS-1:0] highest_next;

   // Only the low address bits matter, so everything wraps at MEM_BYTES
   assign offset   = addr[1:0];
   assign base_row = addr[`MEM_ADDR_BITS-1:2];
   assign next_row = base_row + `MEM_ROW_BITS'(1);

   assign store_u.word = data_in;

   // No lane may write while reset is asserted
   assign store_active = enable & wr & ~rst;

   // Bytes touched by the access
   always_comb begin
      case (length)
         mem_pkg::LEN_BYTE: num_bytes = 3'd1;
         mem_pkg::LEN_HALF: num_bytes = 3'd2;
         mem_pkg::LEN_WORD: num_bytes = 3'd4;
         default:           num_bytes = 3'd0;
      endcase
   end

   genvar k;
   generate
      for (k = 0; k < `MEM_LANES; k++) begin : g_lane
         logic [1:0] byte_idx;

         // Position of this lane's byte within the access
         assign byte_idx = 2'(k) - offset;

         // Lanes below the offset belong to the next row
         assign lane_row[k]  = (2'(k) < offset) ? next_row : base_row;
         assign lane_we[k]   = store_active & ({1'b0, byte_idx} < num_bytes);
         assign lane_byte[k] = store_u.bytes[byte_idx];

         assign lanes[k].row   = lane_row[k];
         assign lanes[k].we    = lane_we[k];
         assign lanes[k].wdata = lane_byte[k];
      end
   endgenerate

   // Largest byte address among this cycle's writes and the stored mark
   always_comb begin
      logic [`MEM_ADDR_BITS-1:0] cand;

      highest_next = highest_addr;
      for (int i = 0; i < `MEM_LANES; i++) begin
         cand = {lane_row[i], 2'(i)};
         if (lane_we[i] && (cand > highest_next)) begin
            highest_next = cand;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         highest_addr <= '0;
      end else begin
         highest_addr <= highest_next;
      end
   end

endmodule

`default_nettype wire

//--- source/byte_lane_bank.sv
// One byte lane of storage with clocked write and combinational read
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module byte_lane_bank (
   input  logic      clk,
   input  logic      rst,
   lane_bus_if.bank  lane
);

   logic [7:0] mem [`MEM_ROWS];

   // Whole lane clears on reset so loads after reset read zero
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `MEM_ROWS; i++) begin
            mem[i] <= 8'd0;
         end
      end else if (lane.we) begin
         mem[lane.row] <= lane.wdata;
      end
   end

   // Read shows the addressed row in the same cycle
   assign lane.rdata = mem[lane.row];

endmodule

`default_nettype wire

//--- source/load_lane_merge.sv
// Load merging: lane bytes rotated into address order, then width extension
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module load_lane_merge (
   input  logic                  enable,
   input  logic                  wr,
   input  logic                  sign,
   input  mem_pkg::access_len_e  length,
   input  logic [1:0]            offset,
   lane_bus_if.merge             lanes [`MEM_LANES],
   output logic [31:0]           data_out
);

   logic [7:0]          lane_byte [`MEM_LANES];
   mem_pkg::mem_word_u  load_u;
   logic                read_active;
   logic [7:0]          low_byte;
   logic [7:0]          high_byte;

   genvar k;
   generate
      for (k = 0; k < `MEM_LANES; k++) begin : g_lane
         assign lane_byte[k] = lanes[k].rdata;
      end
   endgenerate

   // Byte at the access address lands in bytes[0]
   always_comb begin
      logic [1:0] sel;

      load_u.word = '0;
      for (int i = 0; i < `MEM_LANES; i++) begin
         sel = offset + 2'(i);
         load_u.bytes[i] = lane_byte[sel];
      end
   end

   assign read_active = enable & ~wr;
   assign low_byte    = load_u.bytes[0];
   assign high_byte   = load_u.bytes[1];

   always_comb begin
      if (!read_active) begin
         data_out = 32'd0;
      end else begin
         case (length)
            mem_pkg::LEN_BYTE: begin
               if (sign) begin
                  data_out = {{24{low_byte[7]}}, low_byte};
               end else begin
                  data_out = {24'd0, low_byte};
               end
            end
            mem_pkg::LEN_HALF: begin
               if (sign) begin
                  data_out = {{16{high_byte[7]}}, high_byte, low_byte};
               end else begin
                  data_out = {16'd0, high_byte, low_byte};
               end
            end
            mem_pkg::LEN_WORD: begin
               data_out = load_u.word;
            end
            // LEN_NONE reads as zero
            default: begin
               data_out = 32'd0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/data_mem_subsystem.sv
// Data memory top: store steering, four byte-lane banks and load merging
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module data_mem_subsystem (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable,
   input  logic                       wr,
   input  logic [1:0]                 length,
   input  logic                       sign,
   input  logic [31:0]                addr,
   input  logic [31:0]                data_in,
   output logic [31:0]                data_out,
   output logic [`MEM_ADDR_BITS-1:0]  highest_addr
);

   mem_pkg::access_len_e  len_code;
   logic [1:0]            offset;

   assign len_code = mem_pkg::access_len_e'(length);
   assign offset   = addr[1:0];

   // One bus per byte lane
   lane_bus_if lane_bus [`MEM_LANES] ();

   store_lane_steer u_steer (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .wr           (wr),
      .length       (len_code),
      .addr         (addr),
      .data_in      (data_in),
      .lanes        (lane_bus),
      .highest_addr (highest_addr)
   );

   genvar k;
   generate
      for (k = 0; k < `MEM_LANES; k++) begin : g_bank
         byte_lane_bank u_bank (
            .clk  (clk),
            .rst  (rst),
            .lane (lane_bus[k])
         );
      end
   endgenerate

   load_lane_merge u_merge (
      .enable   (enable),
      .wr       (wr),
      .sign     (sign),
      .length   (len_code),
      .offset   (offset),
      .lanes    (lane_bus),
      .data_out (data_out)
   );

endmodule

`default_nettype wire

//--- tests/data_mem_checker.sv
// Output checker: compares data_out and highest_addr with the table row under test
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module data_mem_checker #(
   parameter int SAMPLE_DELAY = 38
) (
   input  logic                       clk,
   input  logic                       row_valid,
   input  int                         row_idx,
   input  logic [31:0]                exp_data_out,
   input  logic [`MEM_ADDR_BITS-1:0]  exp_highest,
   input  logic [31:0]                data_out,
   input  logic [`MEM_ADDR_BITS-1:0]  highest_addr,
   output int                         checked_count,
   output int                         error_count
);

   initial begin
      checked_count = 0;
      error_count   = 0;
   end

   // Sampled just before the next rising edge
   always @(posedge clk) begin
      int row_errors;
      #SAMPLE_DELAY;
      if (row_valid) begin
         row_errors = 0;
         if (data_out !== exp_data_out) begin
            $display("[ERROR] %0t row %0d data_out expected %h actual %h",
                     $time, row_idx, exp_data_out, data_out);
            row_errors++;
         end
         if (highest_addr !== exp_highest) begin
            $display("[ERROR] %0t row %0d highest_addr expected %0d actual %0d",
                     $time, row_idx, exp_highest, highest_addr);
            row_errors++;
         end
         checked_count++;
         if (row_errors == 0) begin
            $display("Row %0d ok", row_idx);
         end else begin
            error_count++;
            $display("Row %0d mismatch", row_idx);
         end
      end
   end

endmodule

`default_nettype wire

//--- tests/data_mem_properties.sv
// Assertions bound to the data memory top: load gating and high-water mark rules
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module data_mem_properties (
   input logic                       clk,
   input logic                       rst,
   input logic                       enable,
   input logic                       wr,
   input logic [31:0]                data_out,
   input logic [`MEM_ADDR_BITS-1:0]  highest_addr
);

   int assert_fails = 0;

   // No load result unless the access is an enabled read
   read_gating: assert property (@(posedge clk) (!enable || wr) |-> (data_out == 32'd0))
      else begin
         assert_fails++;
         $error("data_out is nonzero outside an enabled read");
      end

   high_water_monotonic: assert property (
      @(posedge clk) disable iff (rst) highest_addr >= $past(highest_addr))
      else begin
         assert_fails++;
         $error("highest_addr decreased");
      end

   high_water_reset: assert property (@(posedge clk) $past(rst) |-> (highest_addr == '0))
      else begin
         assert_fails++;
         $error("highest_addr not zero after reset");
      end

endmodule

bind data_mem_subsystem data_mem_properties u_props (
   .clk          (clk),
   .rst          (rst),
   .enable       (enable),
   .wr           (wr),
   .data_out     (data_out),
   .highest_addr (highest_addr)
);

`default_nettype wire

//--- tests/data_mem_tb.sv
// Testbench top for the data memory: clock, reset, stimulus table and byte-array model
// Drives the table row by row and prints the closing summary
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module data_mem_tb;

   localparam int MAX_ROWS     = 80;
   localparam int RANDOM_PAIRS = 12;

   typedef struct packed {
      logic                      enable;
      logic                      wr;
      logic [1:0]                length;
      logic                      sign;
      logic [31:0]               addr;
      logic [31:0]               data_in;
      logic [31:0]               exp_data_out;
      logic [`MEM_ADDR_BITS-1:0] exp_highest;
   } stim_row_t;

   logic                      clk;
   logic                      rst;
   logic                      enable;
   logic                      wr;
   logic [1:0]                length;
   logic                      sign;
   logic [31:0]               addr;
   logic [31:0]               data_in;
   logic [31:0]               data_out;
   logic [`MEM_ADDR_BITS-1:0] highest_addr;

   logic                      row_valid;
   int                        row_idx;
   logic [31:0]               exp_data_out;
   logic [`MEM_ADDR_BITS-1:0] exp_highest;
   int                        checked_count;
   int                        error_count;

   stim_row_t                 rows [MAX_ROWS];
   int                        num_rows;
   logic [7:0]                model_mem [`MEM_BYTES];
   logic [`MEM_ADDR_BITS-1:0] model_high;
   int                        seed = 39;
   int                        cycle_count = 0;
   int                        timeout_limit = 10;

   data_mem_subsystem uut (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .wr           (wr),
      .length       (length),
      .sign         (sign),
      .addr         (addr),
      .data_in      (data_in),
      .data_out     (data_out),
      .highest_addr (highest_addr)
   );

   data_mem_checker u_checker (
      .clk           (clk),
      .row_valid     (row_valid),
      .row_idx       (row_idx),
      .exp_data_out  (exp_data_out),
      .exp_highest   (exp_highest),
      .data_out      (data_out),
      .highest_addr  (highest_addr),
      .checked_count (checked_count),
      .error_count   (error_count)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > timeout_limit) begin
         $display("Timeout: run went past %0d clock cycles", timeout_limit);
         $display("Test failed");
         $finish;
      end
   end

   function automatic int access_bytes(input logic [1:0] len);
      case (len)
         2'd0:    return 1;
         2'd1:    return 2;
         2'd2:    return 4;
         default: return 0;
      endcase
   endfunction

   // Little endian, address wraps at the memory size
   function automatic logic [31:0] model_load(input logic [31:0] a, input logic [1:0] len,
                                              input logic sgn);
      logic [31:0] val;
      int          n;
      val = 32'd0;
      n   = access_bytes(len);
      for (int i = 0; i < n; i++) begin
         val[8*i +: 8] = model_mem[(a + 32'(i)) % `MEM_BYTES];
      end
      if (sgn && n == 1) begin
         val = {{24{val[7]}}, val[7:0]};
      end else if (sgn && n == 2) begin
         val = {{16{val[15]}}, val[15:0]};
      end
      return val;
   endfunction

   task automatic model_store(input logic [31:0] a, input logic [1:0] len, input logic [31:0] d);
      int idx;
      for (int i = 0; i < access_bytes(len); i++) begin
         idx = (a + 32'(i)) % `MEM_BYTES;
         model_mem[idx] = d[8*i +: 8];
         if (idx > model_high) begin
            model_high = idx[`MEM_ADDR_BITS-1:0];
         end
      end
   endtask

   task automatic add_row(input logic en, input logic w, input logic [1:0] len, input logic sgn,
                          input logic [31:0] a, input logic [31:0] d, input logic [31:0] exp_do,
                          input logic [`MEM_ADDR_BITS-1:0] exp_hi);
      rows[num_rows] = '{en, w, len, sgn, a, d, exp_do, exp_hi};
      num_rows++;
      if (en && w) begin
         model_store(a, len, d);
      end
   endtask

   task automatic store_row(input logic [1:0] len, input logic [31:0] a, input logic [31:0] d,
                            input logic [`MEM_ADDR_BITS-1:0] exp_hi);
      add_row(1'b1, 1'b1, len, 1'b0, a, d, 32'd0, exp_hi);
   endtask

   task automatic load_row(input logic [1:0] len, input logic sgn, input logic [31:0] a,
                           input logic [31:0] exp_do, input logic [`MEM_ADDR_BITS-1:0] exp_hi);
      add_row(1'b1, 1'b0, len, sgn, a, 32'd0, exp_do, exp_hi);
   endtask

   // Expectations taken from the model state before the row
   task automatic modeled_row(input logic en, input logic w, input logic [1:0] len,
                              input logic sgn, input logic [31:0] a, input logic [31:0] d);
      logic [31:0] exp_do;
      exp_do = (en && !w) ? model_load(a, len, sgn) : 32'd0;
      add_row(en, w, len, sgn, a, d, exp_do, model_high);
   endtask

   // Store of random width, then a load of random width at the same address
   task automatic add_random_pair();
      logic [31:0] r;
      logic [31:0] a;
      logic [31:0] d;
      r = $random(seed);
      a = $random(seed);
      d = $random(seed);
      modeled_row(r[2:0] != 3'd0, 1'b1, r[4:3], 1'b0, a, d);
      modeled_row(r[7:5] != 3'd0, 1'b0, r[9:8], r[10], a, 32'd0);
   endtask

   task automatic build_table();
      num_rows   = 0;
      model_high = '0;
      for (int i = 0; i < `MEM_BYTES; i++) begin
         model_mem[i] = 8'd0;
      end
      // Clear after reset
      for (int a = 0; a < `MEM_BYTES; a += 4) begin
         load_row(mem_pkg::LEN_WORD, 1'b0, 32'(a), 32'd0, 5'd0);
      end
      // Aligned round trip, then half and byte overwrites
      store_row(mem_pkg::LEN_WORD, 32'd0, 32'h1122_3344, 5'd0);
      load_row(mem_pkg::LEN_WORD, 1'b0, 32'd0, 32'h1122_3344, 5'd3);
      store_row(mem_pkg::LEN_HALF, 32'd0, 32'h0000_aabb, 5'd3);
      load_row(mem_pkg::LEN_WORD, 1'b0, 32'd0, 32'h1122_aabb, 5'd3);
      store_row(mem_pkg::LEN_BYTE, 32'd3, 32'h0000_00cc, 5'd3);
      load_row(mem_pkg::LEN_WORD, 1'b0, 32'd0, 32'hcc22_aabb, 5'd3);
      // Sign and zero extension
      store_row(mem_pkg::LEN_HALF, 32'd8, 32'h0000_f085, 5'd3);
      load_row(mem_pkg::LEN_BYTE, 1'b1, 32'd8, 32'hffff_ff85, 5'd9);
      load_row(mem_pkg::LEN_BYTE, 1'b0, 32'd8, 32'h0000_0085, 5'd9);
      load_row(mem_pkg::LEN_HALF, 1'b1, 32'd8, 32'hffff_f085, 5'd9);
      load_row(mem_pkg::LEN_HALF, 1'b0, 32'd8, 32'h0000_f085, 5'd9);
      load_row(mem_pkg::LEN_BYTE, 1'b1, 32'd9, 32'hffff_fff0, 5'd9);
      load_row(mem_pkg::LEN_BYTE, 1'b1, 32'd2, 32'h0000_0022, 5'd9);
      // Word across the row boundary between bytes 7 and 8
      store_row(mem_pkg::LEN_WORD, 32'd6, 32'hdead_beef, 5'd9);
      load_row(mem_pkg::LEN_WORD, 1'b0, 32'd6, 32'hdead_beef, 5'd9);
      load_row(mem_pkg::LEN_BYTE, 1'b0, 32'd6, 32'h0000_00ef, 5'd9);
      load_row(mem_pkg::LEN_BYTE, 1'b0, 32'd7, 32'h0000_00be, 5'd9);
      load_row(mem_pkg::LEN_BYTE, 1'b0, 32'd8, 32'h0000_00ad, 5'd9);
      load_row(mem_pkg::LEN_BYTE, 1'b0, 32'd9, 32'h0000_00de, 5'd9);
      load_row(mem_pkg::LEN_HALF, 1'b0, 32'd7, 32'h0000_adbe, 5'd9);
      // High-water mark follows the top byte of a half
      store_row(mem_pkg::LEN_HALF, 32'd12, 32'h0000_1234, 5'd9);
      load_row(mem_pkg::LEN_HALF, 1'b0, 32'd12, 32'h0000_1234, 5'd13);
      // LEN_NONE and disabled accesses
      add_row(1'b1, 1'b1, mem_pkg::LEN_NONE, 1'b0, 32'd16, 32'hffff_ffff, 32'd0, 5'd13);
      load_row(mem_pkg::LEN_WORD, 1'b0, 32'd16, 32'd0, 5'd13);
      add_row(1'b0, 1'b1, mem_pkg::LEN_WORD, 1'b0, 32'd20, 32'h5555_5555, 32'd0, 5'd13);
      load_row(mem_pkg::LEN_WORD, 1'b0, 32'd20, 32'd0, 5'd13);
      add_row(1'b1, 1'b0, mem_pkg::LEN_NONE, 1'b0, 32'd0, 32'd0, 32'd0, 5'd13);
      add_row(1'b0, 1'b0, mem_pkg::LEN_WORD, 1'b0, 32'd0, 32'd0, 32'd0, 5'd13);
      // Upper address bits ignored
      load_row(mem_pkg::LEN_WORD, 1'b0, 32'h0000_010c, 32'h0000_1234, 5'd13);
      // Word wrapping past the last byte
      store_row(mem_pkg::LEN_WORD, 32'd29, 32'h0102_0304, 5'd13);
      load_row(mem_pkg::LEN_WORD, 1'b0, 32'd29, 32'h0102_0304, 5'd31);
      load_row(mem_pkg::LEN_WORD, 1'b0, 32'd0, 32'hcc22_aa01, 5'd31);
      for (int p = 0; p < RANDOM_PAIRS; p++) begin
         add_random_pair();
      end
   endtask

   task automatic apply_row(input int i);
      enable       = rows[i].enable;
      wr           = rows[i].wr;
      length       = rows[i].length;
      sign         = rows[i].sign;
      addr         = rows[i].addr;
      data_in      = rows[i].data_in;
      exp_data_out = rows[i].exp_data_out;
      exp_highest  = rows[i].exp_highest;
      row_idx      = i;
      row_valid    = 1'b1;
   endtask

   initial begin
      rst          = 1'b1;
      enable       = 1'b0;
      wr           = 1'b0;
      length       = 2'd0;
      sign         = 1'b0;
      addr         = 32'd0;
      data_in      = 32'd0;
      row_valid    = 1'b0;
      row_idx      = 0;
      exp_data_out = 32'd0;
      exp_highest  = '0;
      build_table();
      timeout_limit = num_rows + 10;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0;
      for (int i = 0; i < num_rows; i++) begin
         @(posedge clk);
         #1;
         apply_row(i);
      end
      @(posedge clk);
      #1;
      enable    = 1'b0;
      wr        = 1'b0;
      row_valid = 1'b0;
      @(posedge clk);
      $display("Summary: %0d of %0d rows checked, %0d mismatched, %0d assertion failures",
               checked_count, num_rows, error_count, uut.u_props.assert_fails);
      if (error_count == 0 && uut.u_props.assert_fails == 0 && checked_count == num_rows) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
source/mem_pkg.sv
source/lane_bus_if.sv
source/store_lane_steer.sv
source/byte_lane_bank.sv
source/load_lane_merge.sv
source/data_mem_subsystem.sv
tests/data_mem_checker.sv
tests/data_mem_properties.sv
tests/data_mem_tb.sv
